//--- rtl/mul_pkg.sv
package mul_pkg;

    // ========================================================================
    // Operand and result widths
    // ========================================================================

    // Unsigned operand width.
    localparam int operand_w = 8;

    // Half of an operand, the unit of the product table.
    localparam int nibble_w = 4;

    // Full product width.
    localparam int result_w = 16;

    // ========================================================================
    // Operand views
    // ========================================================================

    // Upper and lower halves of one operand byte.
    typedef struct packed {
        logic [nibble_w-1:0] hi;
        logic [nibble_w-1:0] lo;
    } nibble_s;

    // One operand word, read either as a byte or as two nibbles.
    typedef union packed {
        logic [operand_w-1:0] word;
        nibble_s              nib;
    } operand_u;

endpackage

//--- rtl/ctrl_pkg.sv
package ctrl_pkg;

    // ========================================================================
    // Product table select
    // ========================================================================

    localparam int rom_sel_w = 2;

    // Nibble pair routed to the table, named x half then y half.
    localparam logic [rom_sel_w-1:0] rom_lo_lo = 2'd0;
    localparam logic [rom_sel_w-1:0] rom_hi_lo = 2'd1;
    localparam logic [rom_sel_w-1:0] rom_lo_hi = 2'd2;
    localparam logic [rom_sel_w-1:0] rom_hi_hi = 2'd3;

    // ========================================================================
    // Adder operand select
    // ========================================================================

    localparam int sum_sel_w = 2;

    // Idle adds zero to zero.
    localparam logic [sum_sel_w-1:0] sum_idle  = 2'd0;
    localparam logic [sum_sel_w-1:0] sum_cross = 2'd1;
    localparam logic [sum_sel_w-1:0] sum_shift = 2'd2;
    localparam logic [sum_sel_w-1:0] sum_final = 2'd3;

    // ========================================================================
    // Sequencer
    // ========================================================================

    localparam int step_w = 4;

    // Steps from the capture edge up to and including the result load.
    localparam int mul_steps = 8;

endpackage

//--- rtl/nibble_rom.sv
`timescale 1ns/1ps

module nibble_rom (
    input  logic [mul_pkg::nibble_w-1:0]  a,
    input  logic [mul_pkg::nibble_w-1:0]  b,
    output logic [mul_pkg::operand_w-1:0] product
);

    import mul_pkg::*;

    // ========================================================================
    // Multiplication table
    // ========================================================================

    // One entry for every pair of nibbles, a in the upper index bits.
    logic [operand_w-1:0] prod_table [1 << (2 * nibble_w)];

    // Entries are filled at elaboration, so the table is pure logic.
    for (genvar i = 0; i < (1 << nibble_w); i++) begin : g_row
        for (genvar j = 0; j < (1 << nibble_w); j++) begin : g_col
            assign prod_table[i * (1 << nibble_w) + j] = operand_w'(i * j);
        end
    end

    // ========================================================================
    // Lookup
    // ========================================================================

    // 15 x 15 = 225 is the largest entry and fits in a byte.
    assign product = prod_table[{a, b}];

endmodule

//--- rtl/mul_datapath.sv
`timescale 1ns/1ps

module mul_datapath (
    input  logic                          clk,
    input  logic                          rst,
    input  mul_pkg::operand_u             x,
    input  mul_pkg::operand_u             y,
    input  logic                          ld_xy,
    input  logic                          ld_de0,
    input  logic                          ld_a,
    input  logic                          ld_b,
    input  logic                          ld_de1,
    input  logic                          ld_ab,
    input  logic                          ld_de_abshift,
    input  logic                          ld_res,
    input  logic [ctrl_pkg::rom_sel_w-1:0] sel_rom,
    input  logic [ctrl_pkg::sum_sel_w-1:0] sel_sum,
    output logic [mul_pkg::result_w-1:0]  result
);

    import mul_pkg::*;
    import ctrl_pkg::*;

    operand_u             xr;
    operand_u             yr;
    logic [nibble_w-1:0]  rom_a;
    logic [nibble_w-1:0]  rom_b;
    logic [operand_w-1:0] rom_q;
    logic [operand_w-1:0] de0;
    logic [operand_w-1:0] a;
    logic [operand_w-1:0] b;
    logic [operand_w-1:0] de1;
    logic [operand_w:0]   ab;
    logic [result_w-1:0]  sum;
    logic [result_w-1:0]  add_a;
    logic [result_w-1:0]  add_b;
    logic [result_w-1:0]  add_q;

    // ========================================================================
    // Operand capture and table
    // ========================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            xr <= '0;
            yr <= '0;
        end else if (ld_xy) begin
            xr <= x;
            yr <= y;
        end
    end

    // Nibble pair for this step.
    always_comb begin
        case (sel_rom)
            rom_hi_lo: begin
                rom_a = xr.nib.hi;
                rom_b = yr.nib.lo;
            end
            rom_lo_hi: begin
                rom_a = xr.nib.lo;
                rom_b = yr.nib.hi;
            end
            rom_hi_hi: begin
                rom_a = xr.nib.hi;
                rom_b = yr.nib.hi;
            end
            default: begin
                rom_a = xr.nib.lo;
                rom_b = yr.nib.lo;
            end
        endcase
    end

    nibble_rom rom_i (
        .a       (rom_a),
        .b       (rom_b),
        .product (rom_q)
    );

    // Partial products, one per step.
    always_ff @(posedge clk) begin
        if (rst) begin
            de0 <= '0;
            a   <= '0;
            b   <= '0;
            de1 <= '0;
        end else begin
            if (ld_de0) de0 <= rom_q;
            if (ld_a)   a   <= rom_q;
            if (ld_b)   b   <= rom_q;
            if (ld_de1) de1 <= rom_q;
        end
    end

    // ========================================================================
    // Shared adder
    // ========================================================================

    always_comb begin
        case (sel_sum)
            sum_cross: begin
                add_a = result_w'(a);
                add_b = result_w'(b);
            end
            sum_shift: begin
                add_a = result_w'(ab) << nibble_w;
                add_b = result_w'(de0);
            end
            sum_final: begin
                add_a = sum;
                add_b = {de1, {operand_w{1'b0}}};
            end
            default: begin
                add_a = '0;
                add_b = '0;
            end
        endcase
    end

    // The full product never exceeds 16 bits, so no carry out.
    assign add_q = add_a + add_b;

    always_ff @(posedge clk) begin
        if (rst) begin
            ab     <= '0;
            sum    <= '0;
            result <= '0;
        end else begin
            if (ld_ab)         ab     <= add_q[operand_w:0];
            if (ld_de_abshift) sum    <= add_q;
            if (ld_res)        result <= add_q;
        end
    end

endmodule

//--- rtl/mul_control.sv
`timescale 1ns/1ps

module mul_control (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           start,
    output logic                           ld_xy,
    output logic                           ld_de0,
    output logic                           ld_a,
    output logic                           ld_b,
    output logic                           ld_de1,
    output logic                           ld_ab,
    output logic                           ld_de_abshift,
    output logic                           ld_res,
    output logic [ctrl_pkg::rom_sel_w-1:0] sel_rom,
    output logic [ctrl_pkg::sum_sel_w-1:0] sel_sum,
    output logic                           busy,
    output logic                           done
);

    import ctrl_pkg::*;

    logic [step_w-1:0] step;
    logic              idle;

    // ========================================================================
    // Step counter
    // ========================================================================

    assign idle = (step == '0);
    assign busy = ~idle;

    // Operands are captured on the edge that accepts start.
    assign ld_xy = start & idle;

    always_ff @(posedge clk) begin
        if (rst) begin
            step <= '0;
        end else if (ld_xy) begin
            step <= step_w'(1);
        end else if (step == step_w'(mul_steps - 1)) begin
            step <= '0;
        end else if (!idle) begin
            step <= step + step_w'(1);
        end
    end

    // ========================================================================
    // Step decode
    // ========================================================================

    always_comb begin
        ld_de0        = 1'b0;
        ld_a          = 1'b0;
        ld_b          = 1'b0;
        ld_de1        = 1'b0;
        ld_ab         = 1'b0;
        ld_de_abshift = 1'b0;
        ld_res        = 1'b0;
        sel_rom       = rom_lo_lo;
        sel_sum       = sum_idle;
        case (step)
            step_w'(1): ld_de0 = 1'b1;
            step_w'(2): begin
                ld_a    = 1'b1;
                sel_rom = rom_hi_lo;
            end
            step_w'(3): begin
                ld_b    = 1'b1;
                sel_rom = rom_lo_hi;
            end
            step_w'(4): begin
                ld_de1  = 1'b1;
                sel_rom = rom_hi_hi;
            end
            step_w'(5): begin
                ld_ab   = 1'b1;
                sel_sum = sum_cross;
            end
            step_w'(6): begin
                ld_de_abshift = 1'b1;
                sel_sum       = sum_shift;
            end
            step_w'(7): begin
                ld_res  = 1'b1;
                sel_sum = sum_final;
            end
            default: ;
        endcase
    end

    // Pulse in the cycle after the result load.
    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= ld_res;
        end
    end

endmodule

//--- rtl/mul8_top.sv
`timescale 1ns/1ps

module mul8_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start,
    input  mul_pkg::operand_u            x,
    input  mul_pkg::operand_u            y,
    output logic                         busy,
    output logic                         done,
    output logic [mul_pkg::result_w-1:0] result
);

    import ctrl_pkg::*;

    logic                 ld_xy;
    logic                 ld_de0;
    logic                 ld_a;
    logic                 ld_b;
    logic                 ld_de1;
    logic                 ld_ab;
    logic                 ld_de_abshift;
    logic                 ld_res;
    logic [rom_sel_w-1:0] sel_rom;
    logic [sum_sel_w-1:0] sel_sum;

    // ========================================================================
    // Sequencer and datapath
    // ========================================================================

    mul_control control_i (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .ld_xy         (ld_xy),
        .ld_de0        (ld_de0),
        .ld_a          (ld_a),
        .ld_b          (ld_b),
        .ld_de1        (ld_de1),
        .ld_ab         (ld_ab),
        .ld_de_abshift (ld_de_abshift),
        .ld_res        (ld_res),
        .sel_rom       (sel_rom),
        .sel_sum       (sel_sum),
        .busy          (busy),
        .done          (done)
    );

    mul_datapath datapath_i (
        .clk           (clk),
        .rst           (rst),
        .x             (x),
        .y             (y),
        .ld_xy         (ld_xy),
        .ld_de0        (ld_de0),
        .ld_a          (ld_a),
        .ld_b          (ld_b),
        .ld_de1        (ld_de1),
        .ld_ab         (ld_ab),
        .ld_de_abshift (ld_de_abshift),
        .ld_res        (ld_res),
        .sel_rom       (sel_rom),
        .sel_sum       (sel_sum),
        .result        (result)
    );

endmodule

//--- dv/mul8_chk.sv
`timescale 1ns/1ps

module mul8_chk (
    input logic clk,
    input logic rst,
    input logic ld_xy,
    input logic ld_de0,
    input logic ld_a,
    input logic ld_b,
    input logic ld_de1,
    input logic ld_ab,
    input logic ld_de_abshift,
    input logic ld_res,
    input logic busy,
    input logic done
);

    logic [7:0] strobes;

    // Read back by the testbench for its closing report.
    int fail_cnt = 0;

    assign strobes = {ld_xy, ld_de0, ld_a, ld_b, ld_de1, ld_ab, ld_de_abshift, ld_res};

    // ========================================================================
    // Control timing
    // ========================================================================

    // No two registers load in the same step; idle cycles load none.
    a_one_strobe: assert property (@(posedge clk) disable iff (rst) $onehot0(strobes))
        else begin
            $error("More than one load strobe is high");
            fail_cnt++;
        end

    a_done_after_res: assert property (@(posedge clk) disable iff (rst) ld_res |=> done)
        else begin
            $error("done did not follow the result load");
            fail_cnt++;
        end

    a_idle_on_done: assert property (@(posedge clk) disable iff (rst) done |-> !busy)
        else begin
            $error("busy is high in the done cycle");
            fail_cnt++;
        end

endmodule

//--- dv/mul8_monitor.sv
`timescale 1ns/1ps

module mul8_monitor (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  logic [mul_pkg::operand_w-1:0] x,
    input  logic [mul_pkg::operand_w-1:0] y,
    input  logic                          busy,
    input  logic                          done,
    input  logic [mul_pkg::result_w-1:0]  result,
    output int                            err_cnt,
    output int                            check_cnt,
    output int                            done_cnt
);

    import mul_pkg::*;
    import ctrl_pkg::*;

    logic [result_w-1:0] prod_q [$];
    logic [result_w-1:0] held;
    logic                done_exp;
    int                  left;

    task automatic compare(input string name, input logic [result_w-1:0] got,
                           input logic [result_w-1:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Fail %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // ========================================================================
    // Cycle model
    // ========================================================================

    // Outputs are sampled at the rising edge, before the DUT updates them.
    // left counts the busy cycles still ahead of the current one.
    always @(posedge clk) begin
        if (rst) begin
            left     = 0;
            done_exp = 1'b0;
            held     = '0;
            prod_q.delete();
        end else begin
            compare("busy", result_w'(busy), result_w'(left != 0));
            compare("done", result_w'(done), result_w'(done_exp));
            if (done_exp) begin
                if (prod_q.size() == 0) begin
                    err_cnt++;
                    $display("A result was due but no start had been accepted at %0t", $time);
                end else begin
                    held = prod_q.pop_front();
                    done_cnt++;
                end
            end
            // Between done pulses the result must not move.
            compare("result", result, held);
            done_exp = (left == 1);
            if (left != 0) begin
                left--;
            end else if (start) begin
                prod_q.push_back(result_w'(x) * result_w'(y));
                left = mul_steps - 1;
            end
        end
    end

endmodule

//--- dv/mul8_tb.sv
`timescale 1ns/1ps

module mul8_tb;

    import mul_pkg::*;
    import ctrl_pkg::*;

    localparam int seed          = 64025;
    localparam int n_ops         = 400;
    localparam int clk_period_ns = 4;
    localparam int rst_cycles    = 10;
    localparam int max_gap       = 6;

    // Every operation takes its steps plus at most one idle gap.
    localparam int timeout_ns =
        (n_ops * (mul_steps + max_gap) + rst_cycles + 20) * clk_period_ns;

    logic                 clk;
    logic                 rst;
    logic                 start;
    logic [operand_w-1:0] x;
    logic [operand_w-1:0] y;
    logic                 busy;
    logic                 done;
    logic [result_w-1:0]  result;

    int mon_err;
    int mon_checks;
    int mon_done;

    logic [operand_w-1:0] corners [5] = '{8'd0, 8'd1, 8'd15, 8'd16, 8'd255};

    mul8_top dut_i (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .x      (x),
        .y      (y),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    mul8_monitor mon_i (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .x         (x),
        .y         (y),
        .busy      (busy),
        .done      (done),
        .result    (result),
        .err_cnt   (mon_err),
        .check_cnt (mon_checks),
        .done_cnt  (mon_done)
    );

    bind mul_control mul8_chk chk_i (
        .clk           (clk),
        .rst           (rst),
        .ld_xy         (ld_xy),
        .ld_de0        (ld_de0),
        .ld_a          (ld_a),
        .ld_b          (ld_b),
        .ld_de1        (ld_de1),
        .ld_ab         (ld_ab),
        .ld_de_abshift (ld_de_abshift),
        .ld_res        (ld_res),
        .busy          (busy),
        .done          (done)
    );

    always #(clk_period_ns / 2) clk = ~clk;

    // ========================================================================
    // Stimulus
    // ========================================================================

    // Called on a falling edge with busy low. Returns after the idle gap.
    task automatic run_op(input logic [operand_w-1:0] xa, input logic [operand_w-1:0] ya);
        int gap;
        start = 1'b1;
        x     = xa;
        y     = ya;
        @(negedge clk);
        start = 1'b0;
        x     = operand_w'($urandom);
        y     = operand_w'($urandom);
        while (!done) begin
            // Stray starts while busy, with fresh operands.
            start = ($urandom_range(0, 7) == 0);
            x     = operand_w'($urandom);
            y     = operand_w'($urandom);
            @(negedge clk);
        end
        start = 1'b0;
        // A zero gap starts the next operation in the done cycle.
        gap = ($urandom_range(0, 2) == 0) ? 0 : int'($urandom_range(1, max_gap));
        repeat (gap) @(negedge clk);
    endtask

    initial begin
        int ops_done;
        int total_err;
        void'($urandom(seed));
        clk   = 1'b0;
        rst   = 1'b1;
        start = 1'b0;
        x     = '0;
        y     = '0;
        repeat (rst_cycles) @(posedge clk);
        @(negedge clk);
        rst      = 1'b0;
        ops_done = 0;
        repeat (3) @(negedge clk);

        foreach (corners[i]) begin
            foreach (corners[j]) begin
                run_op(corners[i], corners[j]);
                ops_done++;
            end
        end
        while (ops_done < n_ops) begin
            run_op(operand_w'($urandom), operand_w'($urandom));
            ops_done++;
        end
        repeat (4) @(negedge clk);

        // ====================================================================
        // Report
        // ====================================================================

        total_err = mon_err + dut_i.control_i.chk_i.fail_cnt;
        if (mon_done != n_ops) begin
            total_err++;
            $display("Fail done_cnt: got 0x%0h, expected 0x%0h", mon_done, n_ops);
        end
        $display("Errors: %0d, checks: %0d, assertion failures: %0d",
                 total_err, mon_checks, dut_i.control_i.chk_i.fail_cnt);
        if (total_err == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog.
    initial begin
        #(timeout_ns);
        $display("Timeout: the run did not complete within %0d ns", timeout_ns);
        $display("Something failed");
        $finish;
    end

endmodule

//--- build.f
rtl/mul_pkg.sv
rtl/ctrl_pkg.sv
rtl/nibble_rom.sv
rtl/mul_datapath.sv
rtl/mul_control.sv
rtl/mul8_top.sv
dv/mul8_chk.sv
dv/mul8_monitor.sv
dv/mul8_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the multiplier testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mul8_tb -f build.f
if [ $? -ne 0 ]; then
    echo "Compilation failed"
    exit 1
fi

# Let every assertion failure reach the testbench report.
out=$(./obj_dir/Vmul8_tb +verilator+error+limit+1000)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1
